//--- pkt_pkg.sv
// ********************
// shared types and constants for the host packet link
// every width is fixed by the byte protocol, so nothing here is tunable
// report lengths include the leading opcode byte
// ********************
package pkt_pkg;

    // host link byte and payload fields
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  fire_addr_t;
    typedef logic [7:0]  metric_addr_t;
    typedef logic [31:0] net_time_t;

    // position of a byte inside one report, max report is 5 bytes
    typedef logic [2:0]  frame_idx_t;

    // host opcodes, also reused as report opcodes
    localparam byte_t OP_STEP      = 8'h01;
    localparam byte_t OP_METRIC    = 8'h02;
    localparam byte_t OP_FIRE_FLAG = 8'h80;

    typedef enum logic [1:0] {
        REPORT_NONE,
        REPORT_TIME,
        REPORT_FIRE,
        REPORT_METRIC
    } report_kind_t;

    // bytes per report, opcode included
    function automatic frame_idx_t report_len(report_kind_t kind);
        case (kind)
            REPORT_TIME:   return 3'd5;
            REPORT_FIRE:   return 3'd2;
            REPORT_METRIC: return 3'd3;
            default:       return 3'd1;
        endcase
    endfunction

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_FIRE,
        RX_STEP,
        RX_METRIC
    } rx_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

endpackage

//--- tx_frame_if.sv
// ********************
// framing signals shared by the tx scheduler, byte counter and builder
// kind is REPORT_NONE whenever no report is in progress
// fire means a tx byte is accepted on this edge
// ********************
`timescale 1ns/1ps

interface tx_frame_if import pkt_pkg::*; ();

    report_kind_t kind;
    logic         start;
    frame_idx_t   idx;
    logic         last;
    logic         fire;

    modport scheduler (
        output kind,
        output start,
        input  last,
        input  fire
    );

    modport counter (
        input  kind,
        input  start,
        input  fire,
        output idx,
        output last
    );

    modport builder (
        input  kind,
        input  start,
        input  idx,
        input  last,
        output fire
    );

endinterface

//--- rx_command_fsm.sv
// ********************
// host command decoder: fire (0x80|a, v), step (0x01, n), metric (0x02, m)
// other opcodes with bit 7 clear are dropped after one byte
// rx_rdy is held low while the core is busy with time
// one request at a time, held until ack or metric_sent
// ********************
`timescale 1ns/1ps

module rx_command_fsm import pkt_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  byte_t        rx_data,
    input  logic         rx_vld,
    output logic         rx_rdy,

    input  logic         time_update,
    input  logic         time_remaining,

    output fire_addr_t   input_fire_addr,
    output byte_t        input_fire_value,
    output logic         input_fire_waiting,
    input  logic         input_fire_ack,

    output byte_t        time_target_value,
    output logic         time_target_waiting,
    input  logic         time_target_ack,

    output metric_addr_t metric_addr,
    output logic         metric_read,
    input  logic         metric_sent
);

    rx_state_t state;
    logic      open;
    logic      accept;

    // ready when waiting for a byte and no request is outstanding
    always_comb begin
        case (state)
            RX_FIRE:   open = !input_fire_waiting;
            RX_STEP:   open = !time_target_waiting;
            RX_METRIC: open = !metric_read;
            default:   open = 1'b1;
        endcase
    end

    assign rx_rdy = open && !(time_update || time_remaining);
    assign accept = rx_vld && rx_rdy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= RX_IDLE;
            input_fire_waiting  <= 1'b0;
            time_target_waiting <= 1'b0;
            metric_read         <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (accept) begin
                        if (rx_data[7]) begin
                            // low opcode bits carry the neuron address
                            input_fire_addr <= {1'b0, rx_data[6:0]};
                            state           <= RX_FIRE;
                        end else if (rx_data == OP_STEP) begin
                            state <= RX_STEP;
                        end else if (rx_data == OP_METRIC) begin
                            state <= RX_METRIC;
                        end
                    end
                end
                RX_FIRE: begin
                    if (input_fire_waiting) begin
                        if (input_fire_ack) begin
                            input_fire_waiting <= 1'b0;
                            state              <= RX_IDLE;
                        end
                    end else if (accept) begin
                        input_fire_value   <= rx_data;
                        input_fire_waiting <= 1'b1;
                    end
                end
                RX_STEP: begin
                    if (time_target_waiting) begin
                        if (time_target_ack) begin
                            time_target_waiting <= 1'b0;
                            state               <= RX_IDLE;
                        end
                    end else if (accept) begin
                        time_target_value   <= rx_data;
                        time_target_waiting <= 1'b1;
                    end
                end
                RX_METRIC: begin
                    // done once the reply has left the tx side
                    if (metric_read) begin
                        if (metric_sent) begin
                            metric_read <= 1'b0;
                            state       <= RX_IDLE;
                        end
                    end else if (accept) begin
                        metric_addr <= rx_data;
                        metric_read <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // a new request never overlaps one still in flight
    a_single_request: assert property (@(posedge clk) disable iff (reset)
        ($rose(input_fire_waiting) || $rose(time_target_waiting) || $rose(metric_read))
        |-> $onehot({input_fire_waiting, time_target_waiting, metric_read}));

endmodule

//--- tx_scheduler_fsm.sv
// ********************
// picks the next report: time first, then output fire, then metric
// a source is served once per sent pulse and must drop its request
// before it can be picked again
// ********************
`timescale 1ns/1ps

module tx_scheduler_fsm import pkt_pkg::*; (
    input  logic clk,
    input  logic reset,

    input  logic time_update,
    input  logic time_remaining,
    input  logic output_fire_waiting,
    input  logic metric_read,
    input  logic tx_vld,

    output logic time_sent,
    output logic output_fire_sent,
    output logic metric_sent,

    tx_frame_if.scheduler frame
);

    tx_state_t    state;
    report_kind_t kind_q;
    report_kind_t pick;
    logic         time_pend;
    logic         fire_pend;
    logic         metric_pend;

    // time goes out once the step ends, or early if a fire is queued behind it
    assign time_pend   = time_update && (!time_remaining || output_fire_waiting) && !time_sent;
    assign fire_pend   = output_fire_waiting && !output_fire_sent;
    assign metric_pend = metric_read && !metric_sent;

    always_comb begin
        if (time_pend) begin
            pick = REPORT_TIME;
        end else if (fire_pend) begin
            pick = REPORT_FIRE;
        end else if (metric_pend) begin
            pick = REPORT_METRIC;
        end else begin
            pick = REPORT_NONE;
        end
    end

    assign frame.start = (state == TX_IDLE) && !tx_vld && (pick != REPORT_NONE);
    assign frame.kind  = frame.start ? pick : kind_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= TX_IDLE;
            kind_q           <= REPORT_NONE;
            time_sent        <= 1'b0;
            output_fire_sent <= 1'b0;
            metric_sent      <= 1'b0;
        end else begin
            time_sent        <= 1'b0;
            output_fire_sent <= 1'b0;
            metric_sent      <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (frame.start) begin
                        kind_q <= pick;
                        state  <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    // last byte taken, tell the source on the same edge tx_vld drops
                    if (frame.fire && frame.last) begin
                        state  <= TX_IDLE;
                        kind_q <= REPORT_NONE;
                        case (kind_q)
                            REPORT_TIME:   time_sent        <= 1'b1;
                            REPORT_FIRE:   output_fire_sent <= 1'b1;
                            REPORT_METRIC: metric_sent      <= 1'b1;
                            default:       ;
                        endcase
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_one_sent: assert property (@(posedge clk) disable iff (reset)
        $onehot0({time_sent, output_fire_sent, metric_sent}));

endmodule

//--- frame_byte_counter.sv
// ********************
// tracks which byte of the current report sits on tx_data
// idx is back at zero between reports
// ********************
`timescale 1ns/1ps

module frame_byte_counter import pkt_pkg::*; (
    input  logic clk,
    input  logic reset,

    tx_frame_if.counter frame
);

    frame_idx_t last_idx;

    assign last_idx   = frame_idx_t'(report_len(frame.kind) - 3'd1);
    assign frame.last = (frame.idx == last_idx);

    always_ff @(posedge clk) begin
        if (reset) begin
            frame.idx <= '0;
        end else if (frame.start || (frame.fire && frame.last)) begin
            frame.idx <= '0;
        end else if (frame.fire) begin
            frame.idx <= frame.idx + 3'd1;
        end
    end

    // the index must stay inside the report that is being sent
    a_idx_in_frame: assert property (@(posedge clk) disable iff (reset)
        (frame.kind != REPORT_NONE) |-> (frame.idx < report_len(frame.kind)));

endmodule

//--- tx_frame_builder.sv
// ********************
// serializes one report onto the host tx byte port
// payload is sampled at start, so later source changes do not leak in
// time is sent most significant byte first
// tx_data is only meaningful while tx_vld is high
// ********************
`timescale 1ns/1ps

module tx_frame_builder import pkt_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  net_time_t    time_current,
    input  fire_addr_t   output_fire_addr,
    input  metric_addr_t metric_addr,
    input  byte_t        metric_value,

    output byte_t        tx_data,
    output logic         tx_vld,
    input  logic         tx_rdy,

    tx_frame_if.builder  frame
);

    net_time_t    time_q;
    fire_addr_t   fire_addr_q;
    metric_addr_t metric_addr_q;
    byte_t        metric_value_q;
    frame_idx_t   sel_idx;
    byte_t        next_byte;

    assign frame.fire = tx_vld && tx_rdy;

    always_ff @(posedge clk) begin
        if (frame.start) begin
            time_q         <= time_current;
            fire_addr_q    <= output_fire_addr;
            metric_addr_q  <= metric_addr;
            metric_value_q <= metric_value;
        end
    end

    // opcode at start, otherwise the byte after the one just taken
    always_comb begin
        sel_idx = frame.start ? 3'd0 : frame.idx + 3'd1;
        case (frame.kind)
            REPORT_TIME: begin
                case (sel_idx)
                    3'd0:    next_byte = OP_STEP;
                    3'd1:    next_byte = time_q[31:24];
                    3'd2:    next_byte = time_q[23:16];
                    3'd3:    next_byte = time_q[15:8];
                    default: next_byte = time_q[7:0];
                endcase
            end
            REPORT_FIRE:
                next_byte = (sel_idx == 3'd0) ? OP_FIRE_FLAG : fire_addr_q;
            REPORT_METRIC: begin
                case (sel_idx)
                    3'd0:    next_byte = OP_METRIC;
                    3'd1:    next_byte = metric_addr_q;
                    default: next_byte = metric_value_q;
                endcase
            end
            default: next_byte = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (frame.start || (frame.fire && !frame.last)) begin
            tx_data <= next_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_vld <= 1'b0;
        end else if (frame.start) begin
            tx_vld <= 1'b1;
        end else if (frame.fire && frame.last) begin
            tx_vld <= 1'b0;
        end
    end

    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        (tx_vld && !tx_rdy) |=> (tx_vld && $stable(tx_data)));

endmodule

//--- packet_link_top.sv
// ********************
// host packet link for the spiking core
// byte ports use valid/ready, a byte moves when both are high
// core requests stay high until their ack or sent flag
// ********************
`timescale 1ns/1ps

module packet_link_top import pkt_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    // host to link
    input  byte_t        rx_data,
    input  logic         rx_vld,
    output logic         rx_rdy,

    // link to host
    output byte_t        tx_data,
    output logic         tx_vld,
    input  logic         tx_rdy,

    output fire_addr_t   input_fire_addr,
    output byte_t        input_fire_value,
    output logic         input_fire_waiting,
    input  logic         input_fire_ack,

    output byte_t        time_target_value,
    output logic         time_target_waiting,
    input  logic         time_target_ack,

    output metric_addr_t metric_addr,
    output logic         metric_read,
    input  byte_t        metric_value,

    input  net_time_t    time_current,
    input  logic         time_update,
    input  logic         time_remaining,
    output logic         time_sent,

    input  fire_addr_t   output_fire_addr,
    input  logic         output_fire_waiting,
    output logic         output_fire_sent
);

    logic metric_sent;

    tx_frame_if frame ();

    rx_command_fsm u_rx_command_fsm (
        .clk                 (clk),
        .reset               (reset),
        .rx_data             (rx_data),
        .rx_vld              (rx_vld),
        .rx_rdy              (rx_rdy),
        .time_update         (time_update),
        .time_remaining      (time_remaining),
        .input_fire_addr     (input_fire_addr),
        .input_fire_value    (input_fire_value),
        .input_fire_waiting  (input_fire_waiting),
        .input_fire_ack      (input_fire_ack),
        .time_target_value   (time_target_value),
        .time_target_waiting (time_target_waiting),
        .time_target_ack     (time_target_ack),
        .metric_addr         (metric_addr),
        .metric_read         (metric_read),
        .metric_sent         (metric_sent)
    );

    tx_scheduler_fsm u_tx_scheduler_fsm (
        .clk                 (clk),
        .reset               (reset),
        .time_update         (time_update),
        .time_remaining      (time_remaining),
        .output_fire_waiting (output_fire_waiting),
        .metric_read         (metric_read),
        .tx_vld              (tx_vld),
        .time_sent           (time_sent),
        .output_fire_sent    (output_fire_sent),
        .metric_sent         (metric_sent),
        .frame               (frame.scheduler)
    );

    frame_byte_counter u_frame_byte_counter (
        .clk   (clk),
        .reset (reset),
        .frame (frame.counter)
    );

    tx_frame_builder u_tx_frame_builder (
        .clk              (clk),
        .reset            (reset),
        .time_current     (time_current),
        .output_fire_addr (output_fire_addr),
        .metric_addr      (metric_addr),
        .metric_value     (metric_value),
        .tx_data          (tx_data),
        .tx_vld           (tx_vld),
        .tx_rdy           (tx_rdy),
        .frame            (frame.builder)
    );

endmodule

//--- tb_core_model.sv
// ********************
// behavioral spiking core for the link testbench
// fire and step requests are acked after 1 to 4 cycles
// metric registers read back as address xor 0x5a
// time and output fire events start on a one-cycle raise from the testbench
// ********************
`timescale 1ns/1ps

module tb_core_model #(
    parameter integer start_seed = 1
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        input_fire_waiting,
    output logic        input_fire_ack,
    input  logic        time_target_waiting,
    output logic        time_target_ack,

    input  logic [7:0]  metric_addr,
    output logic [7:0]  metric_value,

    // event commands from the testbench
    input  logic        time_raise,
    input  logic [31:0] time_value,
    input  logic        fire_raise,
    input  logic [7:0]  fire_addr,

    output logic [31:0] time_current,
    output logic        time_update,
    input  logic        time_sent,
    output logic [7:0]  output_fire_addr,
    output logic        output_fire_waiting,
    input  logic        output_fire_sent
);

    integer      seed;
    logic [31:0] rnd;
    logic [2:0]  fire_cnt;
    logic [2:0]  fire_delay;
    logic [2:0]  step_cnt;
    logic [2:0]  step_delay;

    assign metric_value = metric_addr ^ 8'h5a;

    initial begin
        seed                = start_seed;
        input_fire_ack      = 1'b0;
        time_target_ack     = 1'b0;
        time_current        = '0;
        time_update         = 1'b0;
        output_fire_addr    = '0;
        output_fire_waiting = 1'b0;
        fire_cnt            = '0;
        fire_delay          = 3'd1;
        step_cnt            = '0;
        step_delay          = 3'd1;
        forever begin
            @(posedge clk);
            if (reset) begin
                input_fire_ack      <= 1'b0;
                time_target_ack     <= 1'b0;
                time_update         <= 1'b0;
                output_fire_waiting <= 1'b0;
                fire_cnt            <= '0;
                step_cnt            <= '0;
            end else begin
                // ack is a single cycle, request drops on the same edge
                if (input_fire_ack) begin
                    input_fire_ack <= 1'b0;
                end else if (input_fire_waiting) begin
                    if (fire_cnt == fire_delay - 3'd1) begin
                        rnd = $random(seed);
                        input_fire_ack <= 1'b1;
                        fire_cnt       <= '0;
                        fire_delay     <= {1'b0, rnd[1:0]} + 3'd1;
                    end else begin
                        fire_cnt <= fire_cnt + 3'd1;
                    end
                end
                if (time_target_ack) begin
                    time_target_ack <= 1'b0;
                end else if (time_target_waiting) begin
                    if (step_cnt == step_delay - 3'd1) begin
                        rnd = $random(seed);
                        time_target_ack <= 1'b1;
                        step_cnt        <= '0;
                        step_delay      <= {1'b0, rnd[1:0]} + 3'd1;
                    end else begin
                        step_cnt <= step_cnt + 3'd1;
                    end
                end
                // events stay up until the link reports them
                if (time_raise) begin
                    time_update  <= 1'b1;
                    time_current <= time_value;
                end else if (time_sent) begin
                    time_update <= 1'b0;
                end
                if (fire_raise) begin
                    output_fire_waiting <= 1'b1;
                    output_fire_addr    <= fire_addr;
                end else if (output_fire_sent) begin
                    output_fire_waiting <= 1'b0;
                end
            end
        end
    end

endmodule

//--- tb_packet_link.sv
// ********************
// testbench for packet_link_top with a behavioral core
// tx_rdy is held high in the directed tests and random in the stress test
// expected tx bytes are queued before each report is triggered
// metric_sent is not a top-level port and is watched inside the DUT
// ********************
`timescale 1ns/1ps

module tb_packet_link;

    localparam integer seed_init   = 91057;
    localparam integer num_tests   = 6;
    localparam integer cycle_limit = num_tests * 400;
    localparam integer kind_time   = 1;
    localparam integer kind_fire   = 2;
    localparam integer kind_metric = 3;

    logic        clk;
    logic        reset;
    logic [7:0]  rx_data;
    logic        rx_vld;
    logic        rx_rdy;
    logic [7:0]  tx_data;
    logic        tx_vld;
    logic        tx_rdy;
    logic [7:0]  input_fire_addr;
    logic [7:0]  input_fire_value;
    logic        input_fire_waiting;
    logic        input_fire_ack;
    logic [7:0]  time_target_value;
    logic        time_target_waiting;
    logic        time_target_ack;
    logic [7:0]  metric_addr;
    logic        metric_read;
    logic [7:0]  metric_value;
    logic [31:0] time_current;
    logic        time_update;
    logic        time_remaining;
    logic        time_sent;
    logic [7:0]  output_fire_addr;
    logic        output_fire_waiting;
    logic        output_fire_sent;
    logic        time_raise;
    logic [31:0] time_value;
    logic        fire_raise;
    logic [7:0]  fire_addr;

    integer      seed;
    logic [31:0] rnd;
    logic        random_rdy;
    integer      error_count;
    integer      check_count;
    integer      test_num;
    integer      cycle_count;
    integer      rx_taken;
    integer      fire_requests;
    integer      metric_pulses;
    logic [7:0]  exp_q[$];
    logic        last_q[$];
    logic        after_last;
    logic        vld_prev;
    logic        fire_prev;

    packet_link_top u_packet_link_top (.*);

    tb_core_model #(.start_seed(seed_init)) u_core (.*);

    // bytes of one report as the host sees them with the opcode first
    function automatic logic [7:0] report_byte(integer kind, logic [31:0] payload, integer i);
        case (kind)
            kind_time: report_byte = (i == 0) ? 8'h01 : 8'(payload >> (8 * (4 - i)));
            kind_fire: report_byte = (i == 0) ? 8'h80 : payload[7:0];
            default:   report_byte = (i == 0) ? 8'h02 :
                                     (i == 1) ? payload[7:0] : payload[7:0] ^ 8'h5a;
        endcase
    endfunction

    function automatic integer report_length(integer kind);
        return (kind == kind_time) ? 5 : (kind == kind_fire) ? 2 : 3;
    endfunction

    function automatic logic sent_flag(integer kind);
        case (kind)
            kind_time: return time_sent;
            kind_fire: return output_fire_sent;
            default:   return u_packet_link_top.metric_sent;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, expected);
        end
    endtask

    task automatic queue_report(input integer kind, input logic [31:0] payload);
        integer i;
        for (i = 0; i < report_length(kind); i++) begin
            exp_q.push_back(report_byte(kind, payload, i));
            last_q.push_back(i == report_length(kind) - 1);
        end
    endtask

    task automatic send_host_byte(input logic [7:0] b);
        rx_data <= b;
        rx_vld  <= 1'b1;
        @(posedge clk);
        while (!rx_rdy) @(posedge clk);
        rx_vld <= 1'b0;
    endtask

    task automatic raise_events(input logic do_time, input logic [31:0] t,
                                input logic do_fire, input logic [7:0] a);
        time_value <= t;
        time_raise <= do_time;
        fire_addr  <= a;
        fire_raise <= do_fire;
        @(posedge clk);
        time_raise <= 1'b0;
        fire_raise <= 1'b0;
    endtask

    task automatic wait_sent(input integer kind);
        @(posedge clk);
        while (!sent_flag(kind)) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input integer errors_before);
        check_value("tx bytes still queued", 32'(exp_q.size()), 32'd0);
        test_num++;
        if (error_count == errors_before) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            $display("test %0d %s: fail, %0d failures", test_num, name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        seed   = seed_init;
        tx_rdy = 1'b1;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            tx_rdy <= random_rdy ? rnd[0] : 1'b1;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors found");
        $finish;
    end

    // tx compare and handshake monitor
    initial begin
        rx_taken      = 0;
        fire_requests = 0;
        metric_pulses = 0;
        after_last    = 1'b0;
        vld_prev      = 1'b0;
        fire_prev     = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset) begin
                if ((time_sent || output_fire_sent || u_packet_link_top.metric_sent)
                        && !after_last) begin
                    error_count++;
                    $display("sent pulse at t=%0t without a finished report", $time);
                end
                if (after_last) begin
                    check_value("tx_vld after last byte", 32'(tx_vld), 32'd0);
                    check_value("sent pulse after last byte", 32'(time_sent
                                | output_fire_sent | u_packet_link_top.metric_sent), 32'd1);
                end else if (vld_prev && !tx_vld) begin
                    error_count++;
                    $display("tx_vld fell at t=%0t in the middle of a report", $time);
                end
                after_last = 1'b0;
                if (tx_vld && tx_rdy) begin
                    if (exp_q.size() == 0) begin
                        error_count++;
                        $display("unexpected tx byte %h at t=%0t with no report queued",
                                 tx_data, $time);
                    end else begin
                        check_value("tx_data", 32'(tx_data), 32'(exp_q.pop_front()));
                        after_last = last_q.pop_front();
                    end
                end
                if (rx_vld && rx_rdy) rx_taken++;
                if (u_packet_link_top.metric_sent) metric_pulses++;
                if (input_fire_waiting && !fire_prev) fire_requests++;
            end
            vld_prev  = tx_vld;
            fire_prev = input_fire_waiting;
        end
    end

    initial begin
        integer errs;
        integer n0;
        integer i;
        logic   acked;
        logic   sent_seen;
        logic [7:0] m;
        error_count    = 0;
        check_count    = 0;
        test_num       = 0;
        reset          = 1'b1;
        rx_data        = '0;
        rx_vld         = 1'b0;
        time_remaining = 1'b0;
        time_raise     = 1'b0;
        time_value     = '0;
        fire_raise     = 1'b0;
        fire_addr      = '0;
        random_rdy     = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // input fire gives one request with address and value
        errs = error_count;
        check_value("rx_rdy after reset", 32'(rx_rdy), 32'd1);
        check_value("tx_vld after reset", 32'(tx_vld), 32'd0);
        check_value("input_fire_waiting after reset", 32'(input_fire_waiting), 32'd0);
        n0 = fire_requests;
        send_host_byte(8'h80 | 8'h35);
        send_host_byte(8'hc4);
        @(posedge clk);
        while (!input_fire_waiting) @(posedge clk);
        check_value("input_fire_addr", 32'(input_fire_addr), 32'h35);
        check_value("input_fire_value", 32'(input_fire_value), 32'hc4);
        while (input_fire_waiting) @(posedge clk);
        check_value("rx_rdy after fire ack", 32'(rx_rdy), 32'd1);
        @(posedge clk);
        check_value("input fire requests", 32'(fire_requests - n0), 32'd1);
        finish_test("input fire", errs);

        // step request held until its ack
        errs = error_count;
        send_host_byte(8'h01);
        send_host_byte(8'h2e);
        @(posedge clk);
        while (!time_target_waiting) @(posedge clk);
        check_value("time_target_value", 32'(time_target_value), 32'h2e);
        acked = 1'b0;
        while (time_target_waiting) begin
            if (time_target_ack) acked = 1'b1;
            @(posedge clk);
        end
        check_value("step ack seen before drop", 32'(acked), 32'd1);
        finish_test("step", errs);

        // metric read and reply
        errs = error_count;
        n0 = metric_pulses;
        queue_report(kind_metric, 32'h9c);
        send_host_byte(8'h02);
        send_host_byte(8'h9c);
        @(posedge clk);
        while (!metric_read) @(posedge clk);
        check_value("metric_addr", 32'(metric_addr), 32'h9c);
        wait_sent(kind_metric);
        @(posedge clk);
        check_value("metric_read after reply", 32'(metric_read), 32'd0);
        check_value("rx_rdy after reply", 32'(rx_rdy), 32'd1);
        check_value("metric_sent pulses", 32'(metric_pulses - n0), 32'd1);
        finish_test("metric read", errs);

        // time and fire reports with time first when both pend
        errs = error_count;
        queue_report(kind_time, 32'ha1b2c3d4);
        raise_events(1'b1, 32'ha1b2c3d4, 1'b0, 8'h00);
        wait_sent(kind_time);
        queue_report(kind_fire, 32'h5b);
        raise_events(1'b0, 32'h0, 1'b1, 8'h5b);
        wait_sent(kind_fire);
        queue_report(kind_time, 32'h00000f07);
        queue_report(kind_fire, 32'h3c);
        raise_events(1'b1, 32'h00000f07, 1'b1, 8'h3c);
        wait_sent(kind_fire);
        finish_test("time and fire reports", errs);

        // all reports under random back-pressure
        errs = error_count;
        random_rdy <= 1'b1;
        for (i = 0; i < 3; i++) begin
            m = 8'h40 + i[7:0];
            queue_report(kind_time, 32'h13579bdf + i);
            queue_report(kind_fire, {24'd0, 8'h20 + i[7:0]});
            raise_events(1'b1, 32'h13579bdf + i, 1'b1, 8'h20 + i[7:0]);
            wait_sent(kind_fire);
            queue_report(kind_metric, {24'd0, m});
            send_host_byte(8'h02);
            send_host_byte(m);
            wait_sent(kind_metric);
        end
        random_rdy <= 1'b0;
        @(posedge clk);
        finish_test("random tx_rdy", errs);

        // host bytes blocked while the core works on time
        errs = error_count;
        n0 = rx_taken;
        time_remaining <= 1'b1;
        rx_data        <= 8'h01;
        rx_vld         <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            check_value("rx_rdy with time_remaining", 32'(rx_rdy), 32'd0);
        end
        queue_report(kind_time, 32'h00000100);
        raise_events(1'b1, 32'h00000100, 1'b0, 8'h00);
        repeat (5) begin
            @(posedge clk);
            check_value("rx_rdy with time_update", 32'(rx_rdy), 32'd0);
            check_value("tx_vld while step runs", 32'(tx_vld), 32'd0);
        end
        // only time_update holds the host off from here
        time_remaining <= 1'b0;
        sent_seen = 1'b0;
        while (!sent_seen) begin
            @(posedge clk);
            check_value("rx_rdy during time report", 32'(rx_rdy), 32'd0);
            sent_seen = time_sent;
        end
        rx_vld <= 1'b0;
        @(posedge clk);
        check_value("host bytes taken while blocked", 32'(rx_taken - n0), 32'd0);
        check_value("rx_rdy after time report", 32'(rx_rdy), 32'd1);
        finish_test("rx blocked by time", errs);

        $display("tests: %0d, checks: %0d, failures: %0d", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- packet_link.f
pkt_pkg.sv
tx_frame_if.sv
rx_command_fsm.sv
tx_scheduler_fsm.sv
frame_byte_counter.sv
tx_frame_builder.sv
packet_link_top.sv
tb_core_model.sv
tb_packet_link.sv

//--- Makefile
# Verilator build and run for the packet link testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_packet_link
FILELIST  = packet_link.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
